/* leaf_macros.svh */
`ifndef LEAF_MACROS_SVH
`define LEAF_MACROS_SVH

// ==================================================
// link and packet field widths.
// ==================================================
`define LEAF_PACKET_BITS 49
`define LEAF_PAYLOAD_BITS 32
`define LEAF_ID_BITS 5
`define LEAF_PORT_BITS 4

// ==================================================
// user ports, queues and flow control.
// ==================================================
`define LEAF_NUM_IN_PORTS 5
`define LEAF_NUM_OUT_PORTS 6
// receive queue depth, also the initial credit of a sender.
`define LEAF_QUEUE_DEPTH 8
// words consumed per freespace packet.
`define LEAF_FREESPACE_STEP 4

`endif

/* leaf_pkg.sv */
`include "leaf_macros.svh"

package leaf_pkg;

    typedef logic [`LEAF_PAYLOAD_BITS-1:0] payload_t;
    typedef logic [`LEAF_ID_BITS-1:0] leaf_id_t;
    typedef logic [`LEAF_PORT_BITS-1:0] port_id_t;

    typedef enum logic [1:0] {
        KIND_DATA      = 2'd0,
        KIND_FREESPACE = 2'd1,
        KIND_CONFIG    = 2'd2
    } kind_t;

    // an all-zero packet is an idle link.
    typedef struct packed {
        logic     valid;
        kind_t    kind;
        leaf_id_t dst_leaf;
        port_id_t dst_port;
        leaf_id_t src_leaf;
        payload_t payload;
    } packet_t;

endpackage

/* leaf_fifo.sv */
`timescale 1ns/1ps
`include "leaf_macros.svh"

module leaf_fifo
    import leaf_pkg::*;
#(
    parameter type T = payload_t,
    parameter int DEPTH = `LEAF_QUEUE_DEPTH
) (
    input  logic clk,
    input  logic rst_n,
    input  logic wr_vld,
    input  T     wr_data,
    output logic wr_ack,
    output logic rd_vld,
    output T     rd_data,
    input  logic rd_ack
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);
    localparam logic [PTR_BITS-1:0] LAST = PTR_BITS'(DEPTH - 1);

    T mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic do_wr;
    logic do_rd;

    assign wr_ack = (count != CNT_BITS'(DEPTH));
    assign rd_vld = (count != '0);
    assign rd_data = mem[rd_ptr];
    assign do_wr = wr_vld && wr_ack;
    assign do_rd = rd_vld && rd_ack;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous read and write leaves the count unchanged.
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    // the pointers meet only when the FIFO is empty or full.
    a_count_in_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= CNT_BITS'(DEPTH)
        && ((wr_ptr == rd_ptr) == (count == '0 || count == CNT_BITS'(DEPTH)))
    );

endmodule

/* leaf_rx_path.sv */
`timescale 1ns/1ps
`include "leaf_macros.svh"

module leaf_rx_path
    import leaf_pkg::*;
#(
    parameter leaf_id_t LEAF_ID = leaf_id_t'(3)
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  packet_t                             din_leaf_bft2interface,
    output payload_t [`LEAF_NUM_IN_PORTS-1:0]   dout_leaf_interface2user,
    output logic [`LEAF_NUM_IN_PORTS-1:0]       vld_interface2user,
    input  logic [`LEAF_NUM_IN_PORTS-1:0]       ack_user2interface,
    output logic                                fs_vld,
    output packet_t                             fs_packet,
    input  logic                                fs_ack,
    output logic                                cfg_we,
    output port_id_t                            cfg_port,
    output leaf_id_t                            cfg_leaf,
    output port_id_t                            cfg_dport,
    output logic                                credit_we,
    output port_id_t                            credit_port
);

    localparam int NUM = `LEAF_NUM_IN_PORTS;
    localparam int SEL_BITS = $clog2(NUM);
    localparam int STEP_BITS = (`LEAF_FREESPACE_STEP > 1) ? $clog2(`LEAF_FREESPACE_STEP) : 1;
    localparam logic [STEP_BITS-1:0] STEP_LAST = STEP_BITS'(`LEAF_FREESPACE_STEP - 1);

    packet_t din_r;
    logic mine;
    logic [NUM-1:0] data_we;
    logic [NUM-1:0] q_room;
    logic [NUM-1:0] consumed;
    logic [NUM-1:0] fs_pend;
    logic [STEP_BITS-1:0] used_cnt [NUM];
    leaf_id_t src_leaf_q [NUM];
    logic [SEL_BITS-1:0] fs_sel;

    // ==================================================
    // decode of the registered link word.
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            din_r <= '0;
        end else begin
            din_r <= din_leaf_bft2interface;
        end
    end

    assign mine = din_r.valid && (din_r.dst_leaf == LEAF_ID);

    assign cfg_we    = mine && (din_r.kind == KIND_CONFIG);
    assign cfg_port  = din_r.dst_port;
    assign cfg_leaf  = din_r.payload[8:4];
    assign cfg_dport = din_r.payload[3:0];

    assign credit_we   = mine && (din_r.kind == KIND_FREESPACE);
    assign credit_port = din_r.dst_port;

    // ==================================================
    // per-port user queues and freespace bookkeeping.
    // ==================================================
    for (genvar p = 0; p < NUM; p++) begin : g_port
        assign data_we[p] = mine && (din_r.kind == KIND_DATA)
                            && (din_r.dst_port == port_id_t'(p));
        assign consumed[p] = vld_interface2user[p] && ack_user2interface[p];

        leaf_fifo #(
            .T     (payload_t),
            .DEPTH (`LEAF_QUEUE_DEPTH)
        ) u_queue (
            .clk     (clk),
            .rst_n   (rst_n),
            .wr_vld  (data_we[p]),
            .wr_data (din_r.payload),
            .wr_ack  (q_room[p]),
            .rd_vld  (vld_interface2user[p]),
            .rd_data (dout_leaf_interface2user[p]),
            .rd_ack  (ack_user2interface[p])
        );

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                used_cnt[p]   <= '0;
                fs_pend[p]    <= 1'b0;
                src_leaf_q[p] <= '0;
            end else begin
                if (data_we[p]) begin
                    src_leaf_q[p] <= din_r.src_leaf;
                end
                if (consumed[p]) begin
                    used_cnt[p] <= (used_cnt[p] == STEP_LAST) ? '0 : used_cnt[p] + 1'b1;
                end
                // a new request wins over the ack of the old one.
                fs_pend[p] <= (fs_pend[p] && !(fs_ack && fs_sel == SEL_BITS'(p)))
                              || (consumed[p] && used_cnt[p] == STEP_LAST);
            end
        end
    end

    // lowest pending port goes first.
    always_comb begin
        fs_sel = '0;
        for (int p = NUM - 1; p >= 0; p--) begin
            if (fs_pend[p]) begin
                fs_sel = SEL_BITS'(p);
            end
        end
    end

    assign fs_vld = |fs_pend;

    always_comb begin
        fs_packet          = '0;
        fs_packet.valid    = 1'b1;
        fs_packet.kind     = KIND_FREESPACE;
        fs_packet.dst_leaf = src_leaf_q[fs_sel];
        fs_packet.dst_port = port_id_t'(fs_sel);
        fs_packet.src_leaf = LEAF_ID;
    end

    // the sender must never overrun a queue it holds no credit for.
    a_no_overflow : assert property (
        @(posedge clk) disable iff (!rst_n) (data_we & ~q_room) == '0
    );

endmodule

/* leaf_tx_path.sv */
`timescale 1ns/1ps
`include "leaf_macros.svh"

module leaf_tx_path
    import leaf_pkg::*;
#(
    parameter leaf_id_t LEAF_ID = leaf_id_t'(3)
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  payload_t [`LEAF_NUM_OUT_PORTS-1:0]  din_leaf_user2interface,
    input  logic [`LEAF_NUM_OUT_PORTS-1:0]      vld_user2interface,
    output logic [`LEAF_NUM_OUT_PORTS-1:0]      ack_interface2user,
    input  logic                                cfg_we,
    input  port_id_t                            cfg_port,
    input  leaf_id_t                            cfg_leaf,
    input  port_id_t                            cfg_dport,
    input  logic                                credit_we,
    input  port_id_t                            credit_port,
    output logic                                tx_vld,
    output packet_t                             tx_packet,
    input  logic                                tx_ack
);

    localparam int NUM = `LEAF_NUM_OUT_PORTS;
    localparam int PTR_BITS = $clog2(NUM);
    localparam int CREDIT_BITS = $clog2(`LEAF_QUEUE_DEPTH + 1);

    leaf_id_t dst_leaf_q [NUM];
    port_id_t dst_port_q [NUM];
    logic [CREDIT_BITS-1:0] credit_q [NUM];
    logic [PTR_BITS-1:0] rr_ptr;
    logic [PTR_BITS-1:0] grant_port;
    logic grant_vld;
    logic [NUM-1:0] eligible;
    packet_t pkt_r;
    logic pkt_vld_r;
    logic fifo_wr_ack;
    logic stage_free;

    // the build register may refill in the cycle it drains into the FIFO.
    assign stage_free = !pkt_vld_r || fifo_wr_ack;

    // ==================================================
    // destination table and credit counters.
    // ==================================================
    for (genvar p = 0; p < NUM; p++) begin : g_port
        assign eligible[p] = vld_user2interface[p] && (credit_q[p] != '0) && stage_free;
        assign ack_interface2user[p] = grant_vld && (grant_port == PTR_BITS'(p));

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                dst_leaf_q[p] <= '0;
                dst_port_q[p] <= '0;
                credit_q[p]   <= CREDIT_BITS'(`LEAF_QUEUE_DEPTH);
            end else begin
                if (cfg_we && cfg_port == port_id_t'(p)) begin
                    dst_leaf_q[p] <= cfg_leaf;
                    dst_port_q[p] <= cfg_dport;
                end
                credit_q[p] <= credit_q[p]
                               - CREDIT_BITS'(ack_interface2user[p])
                               + ((credit_we && credit_port == port_id_t'(p))
                                  ? CREDIT_BITS'(`LEAF_FREESPACE_STEP) : '0);
            end
        end

        a_credit_bound : assert property (
            @(posedge clk) disable iff (!rst_n)
            credit_q[p] <= CREDIT_BITS'(`LEAF_QUEUE_DEPTH)
        );
    end

    // ==================================================
    // round-robin grant and packet build.
    // ==================================================
    always_comb begin
        int idx;
        grant_vld  = 1'b0;
        grant_port = '0;
        for (int i = NUM - 1; i >= 0; i--) begin
            idx = (int'(rr_ptr) + i) % NUM;
            if (eligible[idx]) begin
                grant_vld  = 1'b1;
                grant_port = PTR_BITS'(idx);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rr_ptr    <= '0;
            pkt_vld_r <= 1'b0;
        end else begin
            pkt_vld_r <= grant_vld || (pkt_vld_r && !fifo_wr_ack);
            if (grant_vld) begin
                rr_ptr <= (grant_port == PTR_BITS'(NUM - 1)) ? '0 : grant_port + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_vld) begin
            pkt_r.valid    <= 1'b1;
            pkt_r.kind     <= KIND_DATA;
            pkt_r.dst_leaf <= dst_leaf_q[grant_port];
            pkt_r.dst_port <= dst_port_q[grant_port];
            pkt_r.src_leaf <= LEAF_ID;
            pkt_r.payload  <= din_leaf_user2interface[grant_port];
        end
    end

    leaf_fifo #(
        .T     (packet_t),
        .DEPTH (2)
    ) u_tx_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_vld  (pkt_vld_r),
        .wr_data (pkt_r),
        .wr_ack  (fifo_wr_ack),
        .rd_vld  (tx_vld),
        .rd_data (tx_packet),
        .rd_ack  (tx_ack)
    );

endmodule

/* leaf_link_merge.sv */
`timescale 1ns/1ps
`include "leaf_macros.svh"

module leaf_link_merge
    import leaf_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    resend,
    input  logic    fs_vld,
    input  packet_t fs_packet,
    output logic    fs_ack,
    input  logic    tx_vld,
    input  packet_t tx_packet,
    output logic    tx_ack,
    output packet_t dout_leaf_interface2bft
);

    localparam logic [`LEAF_PACKET_BITS-1:0] IDLE = '0;

    packet_t out_r;

    // freespace first, nothing taken during resend.
    assign fs_ack = !resend && fs_vld;
    assign tx_ack = !resend && !fs_vld && tx_vld;

    // a packet blanked by resend stays in the register and goes out afterwards.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_r <= IDLE;
        end else if (!resend) begin
            if (fs_vld) begin
                out_r <= fs_packet;
            end else if (tx_vld) begin
                out_r <= tx_packet;
            end else begin
                out_r <= IDLE;
            end
        end
    end

    assign dout_leaf_interface2bft = resend ? packet_t'(IDLE) : out_r;

endmodule

/* leaf_interface.sv */
`timescale 1ns/1ps
`include "leaf_macros.svh"

module leaf_interface
    import leaf_pkg::*;
#(
    parameter leaf_id_t LEAF_ID = leaf_id_t'(3)
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                resend,
    input  packet_t                             din_leaf_bft2interface,
    output packet_t                             dout_leaf_interface2bft,
    output payload_t [`LEAF_NUM_IN_PORTS-1:0]   dout_leaf_interface2user,
    output logic [`LEAF_NUM_IN_PORTS-1:0]       vld_interface2user,
    input  logic [`LEAF_NUM_IN_PORTS-1:0]       ack_user2interface,
    input  payload_t [`LEAF_NUM_OUT_PORTS-1:0]  din_leaf_user2interface,
    input  logic [`LEAF_NUM_OUT_PORTS-1:0]      vld_user2interface,
    output logic [`LEAF_NUM_OUT_PORTS-1:0]      ack_interface2user
);

    logic     cfg_we;
    port_id_t cfg_port;
    leaf_id_t cfg_leaf;
    port_id_t cfg_dport;
    logic     credit_we;
    port_id_t credit_port;
    logic     fs_vld;
    packet_t  fs_packet;
    logic     fs_ack;
    logic     tx_vld;
    packet_t  tx_packet;
    logic     tx_ack;

    leaf_rx_path #(
        .LEAF_ID (LEAF_ID)
    ) u_rx_path (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .din_leaf_bft2interface   (din_leaf_bft2interface),
        .dout_leaf_interface2user (dout_leaf_interface2user),
        .vld_interface2user       (vld_interface2user),
        .ack_user2interface       (ack_user2interface),
        .fs_vld                   (fs_vld),
        .fs_packet                (fs_packet),
        .fs_ack                   (fs_ack),
        .cfg_we                   (cfg_we),
        .cfg_port                 (cfg_port),
        .cfg_leaf                 (cfg_leaf),
        .cfg_dport                (cfg_dport),
        .credit_we                (credit_we),
        .credit_port              (credit_port)
    );

    leaf_tx_path #(
        .LEAF_ID (LEAF_ID)
    ) u_tx_path (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .din_leaf_user2interface (din_leaf_user2interface),
        .vld_user2interface      (vld_user2interface),
        .ack_interface2user      (ack_interface2user),
        .cfg_we                  (cfg_we),
        .cfg_port                (cfg_port),
        .cfg_leaf                (cfg_leaf),
        .cfg_dport               (cfg_dport),
        .credit_we               (credit_we),
        .credit_port             (credit_port),
        .tx_vld                  (tx_vld),
        .tx_packet               (tx_packet),
        .tx_ack                  (tx_ack)
    );

    leaf_link_merge u_link_merge (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .resend                  (resend),
        .fs_vld                  (fs_vld),
        .fs_packet               (fs_packet),
        .fs_ack                  (fs_ack),
        .tx_vld                  (tx_vld),
        .tx_packet               (tx_packet),
        .tx_ack                  (tx_ack),
        .dout_leaf_interface2bft (dout_leaf_interface2bft)
    );

endmodule

/* leaf_checker.sv */
`timescale 1ns/1ps
`include "leaf_macros.svh"

module leaf_checker
    import leaf_pkg::*;
#(
    parameter leaf_id_t LEAF_ID = leaf_id_t'(3)
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                resend,
    input  packet_t                             din_leaf_bft2interface,
    input  packet_t                             dout_leaf_interface2bft,
    input  payload_t [`LEAF_NUM_IN_PORTS-1:0]   dout_leaf_interface2user,
    input  logic [`LEAF_NUM_IN_PORTS-1:0]       vld_interface2user,
    input  logic [`LEAF_NUM_IN_PORTS-1:0]       ack_user2interface,
    input  payload_t [`LEAF_NUM_OUT_PORTS-1:0]  din_leaf_user2interface,
    input  logic [`LEAF_NUM_OUT_PORTS-1:0]      vld_user2interface,
    input  logic [`LEAF_NUM_OUT_PORTS-1:0]      ack_interface2user,
    output int                                  errors,
    output int                                  outstanding,
    output int                                  fs_seen
);

    packet_t rx_exp[$];
    packet_t link_exp[$];
    packet_t pipe1;
    packet_t pipe2;
    leaf_id_t table_leaf [`LEAF_NUM_OUT_PORTS];
    port_id_t table_port [`LEAF_NUM_OUT_PORTS];
    int credit [`LEAF_NUM_OUT_PORTS];
    int used [`LEAF_NUM_IN_PORTS];
    leaf_id_t last_src [`LEAF_NUM_IN_PORTS];

    function automatic packet_t make_packet(kind_t k, leaf_id_t dl, port_id_t dp,
                                            leaf_id_t sl, payload_t pl);
        packet_t pkt;
        pkt = '{valid: 1'b1, kind: k, dst_leaf: dl, dst_port: dp, src_leaf: sl, payload: pl};
        return pkt;
    endfunction

    // data packets keep order per destination, freespace may come in any order.
    task automatic match_link(packet_t got);
        int idx;
        idx = -1;
        for (int i = 0; i < link_exp.size(); i++) begin
            if (idx < 0 && link_exp[i].kind == got.kind) begin
                if (got.kind != KIND_DATA || (link_exp[i].dst_leaf == got.dst_leaf
                                              && link_exp[i].dst_port == got.dst_port)) begin
                    if (got.kind == KIND_DATA || link_exp[i] == got) begin
                        idx = i;
                    end
                end
            end
        end
        if (idx < 0 || link_exp[idx] != got) begin
            $display("[ERROR] %0t: unexpected link packet %h", $time, got);
            errors++;
        end else begin
            link_exp.delete(idx);
            if (got.kind == KIND_FREESPACE) begin
                fs_seen++;
            end
        end
    endtask

    task automatic take_word(int p, payload_t got);
        int idx;
        idx = -1;
        for (int i = 0; i < rx_exp.size(); i++) begin
            if (idx < 0 && rx_exp[i].dst_port == port_id_t'(p)) begin
                idx = i;
            end
        end
        if (idx < 0 || rx_exp[idx].payload != got) begin
            $display("[ERROR] %0t: rx port %0d got %h, not the expected word", $time, p, got);
            errors++;
        end else begin
            rx_exp.delete(idx);
        end
    endtask

    initial begin
        errors = 0;
        fs_seen = 0;
        outstanding = 0;
    end

    // everything is sampled at the falling edge, away from the driven inputs.
    always @(negedge clk) begin
        if (!rst_n) begin
            rx_exp.delete();
            link_exp.delete();
            pipe1 = '0;
            pipe2 = '0;
            for (int q = 0; q < `LEAF_NUM_OUT_PORTS; q++) begin
                table_leaf[q] = '0;
                table_port[q] = '0;
                credit[q] = `LEAF_QUEUE_DEPTH;
            end
            for (int p = 0; p < `LEAF_NUM_IN_PORTS; p++) begin
                used[p] = 0;
                last_src[p] = '0;
            end
        end else begin
            // config and credit act two samples after they cross the link.
            if (pipe2.valid && pipe2.dst_leaf == LEAF_ID
                && pipe2.dst_port < `LEAF_NUM_OUT_PORTS) begin
                if (pipe2.kind == KIND_CONFIG) begin
                    table_leaf[pipe2.dst_port] = pipe2.payload[8:4];
                    table_port[pipe2.dst_port] = pipe2.payload[3:0];
                end else if (pipe2.kind == KIND_FREESPACE) begin
                    credit[pipe2.dst_port] += `LEAF_FREESPACE_STEP;
                end
            end
            pipe2 = pipe1;
            pipe1 = din_leaf_bft2interface;

            if (din_leaf_bft2interface.valid && din_leaf_bft2interface.dst_leaf == LEAF_ID
                && din_leaf_bft2interface.kind == KIND_DATA) begin
                rx_exp.push_back(din_leaf_bft2interface);
                last_src[din_leaf_bft2interface.dst_port] = din_leaf_bft2interface.src_leaf;
            end

            for (int p = 0; p < `LEAF_NUM_IN_PORTS; p++) begin
                if (vld_interface2user[p] && ack_user2interface[p]) begin
                    take_word(p, dout_leaf_interface2user[p]);
                    used[p]++;
                    if (used[p] == `LEAF_FREESPACE_STEP) begin
                        used[p] = 0;
                        link_exp.push_back(make_packet(KIND_FREESPACE, last_src[p],
                                                       port_id_t'(p), LEAF_ID, '0));
                    end
                end
            end

            for (int q = 0; q < `LEAF_NUM_OUT_PORTS; q++) begin
                if (vld_user2interface[q] && ack_interface2user[q]) begin
                    if (credit[q] == 0) begin
                        $display("[ERROR] %0t: tx port %0d accepted a word without credit",
                                 $time, q);
                        errors++;
                    end
                    credit[q]--;
                    link_exp.push_back(make_packet(KIND_DATA, table_leaf[q], table_port[q],
                                                   LEAF_ID, din_leaf_user2interface[q]));
                end
            end

            if (resend && dout_leaf_interface2bft != '0) begin
                $display("[ERROR] %0t: link not idle during resend", $time);
                errors++;
            end
            if (dout_leaf_interface2bft.valid) begin
                match_link(dout_leaf_interface2bft);
            end
        end
        outstanding = rx_exp.size() + link_exp.size();
    end

endmodule

/* tb_leaf.sv */
`timescale 1ns/1ps
`include "leaf_macros.svh"

module tb_leaf
    import leaf_pkg::*;
();

    localparam leaf_id_t MY_LEAF = leaf_id_t'(3);
    localparam int NUM_TRANS = 150;
    localparam int WATCH_NS = NUM_TRANS * 40 * 20;

    logic clk;
    logic rst_n;
    logic resend;
    packet_t din_leaf_bft2interface;
    packet_t dout_leaf_interface2bft;
    payload_t [`LEAF_NUM_IN_PORTS-1:0] dout_leaf_interface2user;
    logic [`LEAF_NUM_IN_PORTS-1:0] vld_interface2user;
    logic [`LEAF_NUM_IN_PORTS-1:0] ack_user2interface;
    payload_t [`LEAF_NUM_OUT_PORTS-1:0] din_leaf_user2interface;
    logic [`LEAF_NUM_OUT_PORTS-1:0] vld_user2interface;
    logic [`LEAF_NUM_OUT_PORTS-1:0] ack_interface2user;
    logic [`LEAF_NUM_OUT_PORTS-1:0] tx_acked;
    int chk_errors;
    int outstanding;
    int fs_seen;

    logic [31:0] seed = 32'hc3c9_fd97;
    packet_t link_q[$];
    packet_t tx_q[$];
    int acks [`LEAF_NUM_OUT_PORTS];
    int tb_errors;
    int test_num;
    int failed_tests;
    int errs_before;
    int resend_left;
    bit resend_en;

    leaf_interface #(.LEAF_ID(MY_LEAF)) uut (.*);

    leaf_checker #(.LEAF_ID(MY_LEAF)) u_checker (
        .clk(clk), .rst_n(rst_n), .resend(resend),
        .din_leaf_bft2interface(din_leaf_bft2interface),
        .dout_leaf_interface2bft(dout_leaf_interface2bft),
        .dout_leaf_interface2user(dout_leaf_interface2user),
        .vld_interface2user(vld_interface2user), .ack_user2interface(ack_user2interface),
        .din_leaf_user2interface(din_leaf_user2interface),
        .vld_user2interface(vld_user2interface), .ack_interface2user(ack_interface2user),
        .errors(chk_errors), .outstanding(outstanding), .fs_seen(fs_seen)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(negedge clk) begin
        tx_acked <= vld_user2interface & ack_interface2user;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic packet_t build_packet(kind_t k, leaf_id_t dl, port_id_t dp,
                                             leaf_id_t sl, payload_t pl);
        packet_t pkt;
        pkt = '{valid: 1'b1, kind: k, dst_leaf: dl, dst_port: dp, src_leaf: sl, payload: pl};
        return pkt;
    endfunction

    function automatic int find_word(int q);
        for (int i = 0; i < tx_q.size(); i++) begin
            if (tx_q[i].dst_port == port_id_t'(q)) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic report_error(string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        tb_errors++;
    endtask

    // one clock of the network and user model.
    task automatic step_cycle();
        logic [31:0] r;
        int idx;
        @(posedge clk);
        #2;
        r = next_rand();
        for (int q = 0; q < `LEAF_NUM_OUT_PORTS; q++) begin
            if (tx_acked[q]) begin
                tx_q.delete(find_word(q));
                acks[q]++;
                vld_user2interface[q] = 1'b0;
            end
            idx = find_word(q);
            if (idx < 0) begin
                vld_user2interface[q] = 1'b0;
            end else if (!vld_user2interface[q] && r[q + 16]) begin
                vld_user2interface[q] = 1'b1;
                din_leaf_user2interface[q] = tx_q[idx].payload;
            end
        end
        ack_user2interface = r[12:8];
        if (link_q.size() > 0 && r[3]) begin
            din_leaf_bft2interface = link_q.pop_front();
        end else begin
            din_leaf_bft2interface = '0;
        end
        if (resend_left == 0 && resend_en && r[30:28] == 3'd0) begin
            resend_left = 1 + int'(r[1:0]);
        end
        resend = (resend_left > 0);
        if (resend_left > 0) begin
            resend_left--;
        end
    endtask

    task automatic run_until_idle();
        int quiet;
        quiet = 0;
        while (quiet < 8) begin
            step_cycle();
            if (link_q.size() == 0 && tx_q.size() == 0 && outstanding == 0 && !resend) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
    endtask

    task automatic wait_for_acks(int q, int target);
        while (acks[q] < target) begin
            step_cycle();
        end
    endtask

    task automatic queue_rx(int rounds, bit foreign);
        for (int n = 0; n < rounds; n++) begin
            for (int p = 0; p < `LEAF_NUM_IN_PORTS; p++) begin
                link_q.push_back(build_packet(KIND_DATA, MY_LEAF, port_id_t'(p),
                                              leaf_id_t'(8 + p), next_rand()));
                if (foreign && n == 0) begin
                    link_q.push_back(build_packet(KIND_DATA, leaf_id_t'(7), port_id_t'(p),
                                                  leaf_id_t'(1), next_rand()));
                end
            end
        end
    endtask

    task automatic queue_tx(int first, int ports, int words);
        for (int n = 0; n < words; n++) begin
            for (int q = first; q < first + ports; q++) begin
                tx_q.push_back(build_packet(KIND_DATA, '0, port_id_t'(q), '0, next_rand()));
            end
        end
    endtask

    task automatic finish_test(string name);
        test_num++;
        if (chk_errors + tb_errors == errs_before) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: failed", test_num, name);
        end
        errs_before = chk_errors + tb_errors;
    endtask

    initial begin
        int fs_base;
        rst_n = 1'b0;
        resend = 1'b0;
        din_leaf_bft2interface = '0;
        din_leaf_user2interface = '0;
        vld_user2interface = '0;
        ack_user2interface = '0;
        tb_errors = 0;
        test_num = 0;
        failed_tests = 0;
        errs_before = 0;
        resend_left = 0;
        resend_en = 1'b0;
        for (int q = 0; q < `LEAF_NUM_OUT_PORTS; q++) begin
            acks[q] = 0;
        end
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        if (vld_interface2user != '0 || ack_interface2user != '0
            || dout_leaf_interface2bft != '0) begin
            report_error("outputs not idle after reset");
        end
        finish_test("reset");

        // ==================================================
        // configuration, then user words on ports 0 to 4.
        // ==================================================
        for (int q = 0; q < `LEAF_NUM_OUT_PORTS; q++) begin
            link_q.push_back(build_packet(KIND_CONFIG, MY_LEAF, port_id_t'(q), leaf_id_t'(1),
                                          payload_t'({leaf_id_t'(16 + q), port_id_t'(q)})));
        end
        run_until_idle();
        queue_tx(0, 5, 4);
        run_until_idle();
        finish_test("configuration");

        fs_base = fs_seen;
        queue_rx(8, 1'b1);
        run_until_idle();
        finish_test("receive");
        if (fs_seen - fs_base != 10) begin
            report_error("wrong number of freespace packets");
        end
        finish_test("freespace return");

        // ==================================================
        // credit on port 5, nothing returned at first.
        // ==================================================
        queue_tx(5, 1, `LEAF_QUEUE_DEPTH + 2 * `LEAF_FREESPACE_STEP);
        wait_for_acks(5, `LEAF_QUEUE_DEPTH);
        repeat (20) step_cycle();
        if (acks[5] != `LEAF_QUEUE_DEPTH) begin
            report_error("port 5 accepted the wrong number of words on its first credit");
        end
        link_q.push_back(build_packet(KIND_FREESPACE, MY_LEAF, port_id_t'(5),
                                      leaf_id_t'(1), '0));
        wait_for_acks(5, `LEAF_QUEUE_DEPTH + `LEAF_FREESPACE_STEP);
        repeat (20) step_cycle();
        if (acks[5] != `LEAF_QUEUE_DEPTH + `LEAF_FREESPACE_STEP) begin
            report_error("port 5 accepted the wrong number of words after freespace");
        end
        // a second return lets the waiting words drain.
        link_q.push_back(build_packet(KIND_FREESPACE, MY_LEAF, port_id_t'(5),
                                      leaf_id_t'(1), '0));
        run_until_idle();
        finish_test("credit");

        fs_base = fs_seen;
        resend_en = 1'b1;
        queue_rx(8, 1'b0);
        queue_tx(0, 5, 4);
        run_until_idle();
        resend_en = 1'b0;
        run_until_idle();
        if (fs_seen - fs_base != 10) begin
            report_error("freespace packets lost or repeated across resend");
        end
        finish_test("resend");

        $display("tests: %0d, failed: %0d, errors: %0d", test_num, failed_tests,
                 chk_errors + tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCH_NS);
        $display("timeout: the tests did not finish in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* all.f */
+incdir+.
leaf_pkg.sv
leaf_fifo.sv
leaf_rx_path.sv
leaf_tx_path.sv
leaf_link_merge.sv
leaf_interface.sv
leaf_checker.sv
tb_leaf.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_leaf -o sim_leaf

out=$(./obj_dir/sim_leaf)
echo "$out"
echo "$out" | grep -q "Simulation finished: PASS"
